// File: bench/tb_hc_mem.sv
`timescale 1ns/1ns

module tb_hc_mem;
    import hc_pkg::*;

    localparam int N_PROBE = 8;    // unwritten probes per client
    localparam int N_HSYM  = 8;    // small histogram symbol set
    localparam int N_INC   = 200;
    localparam int N_CB    = 16;
    localparam int N_PAIR  = 60;
    localparam int N_OPS   = 2 * N_PROBE + N_INC + 2 * N_CB + N_HSYM + 2 * N_PAIR
                             + N_HSYM + N_CB + N_PROBE;
    // an increment needs about 20 cycles, a lookup about half that
    localparam int MAX_CYCLES = N_OPS * 25 + 100;

    logic              clk = 1'b0;
    logic              rst;
    logic              sym_req_i, sym_query_i, sym_ack_o;
    logic [SYM_W-1:0]  sym_i;
    logic [WORD_W-1:0] hist_count_o;
    logic              cb_req_i, cb_we_i, cb_ack_o, busy_o;
    logic [SYM_W-1:0]  cb_sym_i;
    logic [LEN_W-1:0]  cb_len_i, cb_len_o;
    logic [CODE_W-1:0] cb_code_i, cb_code_o;

    logic [31:0]       lfsr = 32'h8adf;
    int                cycles = 0;
    logic [WORD_W-1:0] hist_model [256];
    logic [LEN_W-1:0]  len_model  [256];
    logic [CODE_W-1:0] code_model [256];
    logic              cb_written [256];
    logic [SYM_W-1:0]  cb_list    [N_CB];  // symbols given a codebook entry

    hc_mem_top uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_run($sformatf("timeout, run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    // taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [SYM_W-1:0] hist_sym(input logic [2:0] k);
        return {k, 5'h0b};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic value_error(input string test, input logic [31:0] exp, input logic [31:0] act);
        stop_run($sformatf("error %s: expected %0h, actual %0h", test, exp, act));
    endtask

    // one increment or query, model count saturates at all ones
    task automatic hist_op(input string test, input logic [SYM_W-1:0] sym, input logic query);
        logic [WORD_W-1:0] exp;
        logic              saw_busy;
        exp = hist_model[sym];
        if (!query && exp != COUNT_MAX) begin
            exp = exp + 1'b1;
        end
        saw_busy = 1'b0;
        @(negedge clk);
        sym_i       = sym;
        sym_query_i = query;
        sym_req_i   = 1'b1;
        do begin
            @(negedge clk);
            saw_busy = saw_busy | busy_o;
        end while (!sym_ack_o);
        assert (hist_count_o == exp) else value_error(test, exp, hist_count_o);
        assert (saw_busy) else stop_run("busy_o stayed low during a histogram op");
        hist_model[sym] = exp;
        sym_req_i = 1'b0;
        do @(negedge clk); while (sym_ack_o);
    endtask

    task automatic cb_op(input string test, input logic we, input logic [SYM_W-1:0] sym,
                         input logic [LEN_W-1:0] len, input logic [CODE_W-1:0] code);
        logic [LEN_W-1:0]  exp_len;
        logic [CODE_W-1:0] exp_code;
        logic              saw_busy;
        exp_len  = cb_written[sym] ? len_model[sym] : '0;  // never written reads zero
        exp_code = cb_written[sym] ? code_model[sym] : '0;
        saw_busy = 1'b0;
        @(negedge clk);
        cb_we_i   = we;
        cb_sym_i  = sym;
        cb_len_i  = len;
        cb_code_i = code;
        cb_req_i  = 1'b1;
        do begin
            @(negedge clk);
            saw_busy = saw_busy | busy_o;
        end while (!cb_ack_o);
        assert (saw_busy) else stop_run("busy_o stayed low during a codebook op");
        if (we) begin
            len_model[sym]  = len;
            code_model[sym] = code;
            cb_written[sym] = 1'b1;
        end else begin
            assert (cb_len_o == exp_len)
                else value_error({test, " len"}, 32'(exp_len), 32'(cb_len_o));
            assert (cb_code_o == exp_code)
                else value_error({test, " code"}, 32'(exp_code), 32'(cb_code_o));
        end
        cb_req_i = 1'b0;
        do @(negedge clk); while (cb_ack_o);
    endtask

    // four-phase rules on both outside handshakes
    assert property (@(posedge clk) disable iff (rst) !sym_req_i && !sym_ack_o |=> !sym_ack_o)
        else stop_run("sym_ack_o rose while sym_req_i was low");
    assert property (@(posedge clk) disable iff (rst) sym_ack_o && sym_req_i |=> sym_ack_o)
        else stop_run("sym_ack_o fell before sym_req_i fell");
    assert property (@(posedge clk) disable iff (rst) sym_ack_o && !sym_req_i |=> !sym_ack_o)
        else stop_run("sym_ack_o stayed high after sym_req_i fell");
    assert property (@(posedge clk) disable iff (rst)
                     sym_ack_o |=> !sym_ack_o || $stable(hist_count_o))
        else stop_run("hist_count_o changed while sym_ack_o was high");
    assert property (@(posedge clk) disable iff (rst) !cb_req_i && !cb_ack_o |=> !cb_ack_o)
        else stop_run("cb_ack_o rose while cb_req_i was low");
    assert property (@(posedge clk) disable iff (rst) cb_ack_o && cb_req_i |=> cb_ack_o)
        else stop_run("cb_ack_o fell before cb_req_i fell");
    assert property (@(posedge clk) disable iff (rst) cb_ack_o && !cb_req_i |=> !cb_ack_o)
        else stop_run("cb_ack_o stayed high after cb_req_i fell");
    assert property (@(posedge clk) disable iff (rst)
                     cb_ack_o |=> !cb_ack_o || ($stable(cb_len_o) && $stable(cb_code_o)))
        else stop_run("codebook result changed while cb_ack_o was high");
    // a client request still waiting for its ack keeps the port busy
    assert property (@(posedge clk) disable iff (rst)
                     uut.op_req && !uut.op_ack |=> busy_o)
        else stop_run("busy_o low while a client request waited for its ack");

    initial begin
        logic [1:0]        pick;
        logic              h_query, c_we;
        logic [SYM_W-1:0]  h_sym, c_sym;
        logic [LEN_W-1:0]  c_len;
        logic [CODE_W-1:0] c_code;
        rst         = 1'b1;
        sym_req_i   = 1'b0;
        sym_query_i = 1'b0;
        sym_i       = '0;
        cb_req_i    = 1'b0;
        cb_we_i     = 1'b0;
        cb_sym_i    = '0;
        cb_len_i    = '0;
        cb_code_i   = '0;
        for (int i = 0; i < 256; i++) begin
            hist_model[i] = '0;
            cb_written[i] = 1'b0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!sym_ack_o && !cb_ack_o && !busy_o)
            else stop_run("an ack or busy_o was high after reset");

        for (int i = 0; i < N_PROBE; i++) begin
            hist_op("reset_query", SYM_W'(take_bits(SYM_W)), 1'b1);
            cb_op("reset_lookup", 1'b0, SYM_W'(take_bits(SYM_W)), '0, '0);
        end
        for (int i = 0; i < N_INC; i++) begin
            hist_op("count_inc", hist_sym(3'(take_bits(3))), 1'b0);
        end

        // entries for every counted symbol plus some random ones
        for (int i = 0; i < N_CB; i++) begin
            cb_list[i] = (i < N_HSYM) ? hist_sym(3'(i)) : SYM_W'(take_bits(SYM_W));
            cb_op("cb_write", 1'b1, cb_list[i], LEN_W'(take_bits(LEN_W)),
                  CODE_W'(take_bits(CODE_W)));
        end
        for (int i = 0; i < N_CB; i++) begin
            cb_op("cb_lookup", 1'b0, cb_list[i], '0, '0);
        end
        for (int i = 0; i < N_HSYM; i++) begin
            hist_op("count_after_cb", hist_sym(3'(i)), 1'b1);
        end

        // pick 0 hist only, 1 codebook only, else both in the same cycle
        for (int i = 0; i < N_PAIR; i++) begin
            pick    = 2'(take_bits(2));
            h_sym   = hist_sym(3'(take_bits(3)));
            h_query = 1'(take_bits(1));
            c_we    = 1'(take_bits(1));
            c_sym   = take_bits(1) != 0 ? cb_list[4'(take_bits(4))] : SYM_W'(take_bits(SYM_W));
            c_len   = LEN_W'(take_bits(LEN_W));
            c_code  = CODE_W'(take_bits(CODE_W));
            fork
                if (pick != 2'd1) hist_op("pair_hist", h_sym, h_query);
                if (pick != 2'd0) cb_op("pair_cb", c_we, c_sym, c_len, c_code);
            join
        end

        for (int i = 0; i < N_HSYM; i++) begin
            hist_op("final_query", hist_sym(3'(i)), 1'b1);
        end
        for (int i = 0; i < N_CB; i++) begin
            cb_op("final_lookup", 1'b0, cb_list[i], '0, '0);
        end
        for (int i = 0; i < N_PROBE; i++) begin
            cb_op("probe_lookup", 1'b0, SYM_W'(take_bits(SYM_W)), '0, '0);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: build.f
design/hc_pkg.sv
design/word_ram.sv
design/sram_port.sv
design/client_arbiter.sv
design/hist_update.sv
design/codebook_unit.sv
design/hc_mem_top.sv
bench/tb_hc_mem.sv

// File: design/client_arbiter.sv
`timescale 1ns/1ns

module client_arbiter (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        h_op_req_i,
    input  logic                        h_op_we_i,
    input  logic [hc_pkg::SYM_W-1:0]    h_op_index_i,
    input  logic [hc_pkg::WORD_W-1:0]   h_op_wdata_i,
    output logic                        h_op_ack_o,
    input  logic                        c_op_req_i,
    input  logic                        c_op_we_i,
    input  logic [hc_pkg::SYM_W-1:0]    c_op_index_i,
    input  logic [hc_pkg::WORD_W-1:0]   c_op_wdata_i,
    output logic                        c_op_ack_o,
    output logic                        op_req_o,
    output logic                        op_we_o,
    output logic [hc_pkg::REGION_W-1:0] op_region_o,
    output logic [hc_pkg::SYM_W-1:0]    op_index_o,
    output logic [hc_pkg::WORD_W-1:0]   op_wdata_o,
    input  logic                        op_ack_i
);
    import hc_pkg::*;

    logic gnt_c_q;  // 1 while the codebook client owns the port
    logic gnt_c;
    logic free;

    // owner quiet and port ack back at zero
    assign free = !(gnt_c_q ? c_op_req_i : h_op_req_i) && !op_ack_i;

    always_comb begin
        gnt_c = gnt_c_q;
        if (free) begin
            if (h_op_req_i) begin
                gnt_c = 1'b0;  // histogram wins a tie
            end else if (c_op_req_i) begin
                gnt_c = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gnt_c_q <= 1'b0;
        end else begin
            gnt_c_q <= gnt_c;
        end
    end

    assign op_req_o    = gnt_c ? c_op_req_i   : h_op_req_i;
    assign op_we_o     = gnt_c ? c_op_we_i    : h_op_we_i;
    assign op_index_o  = gnt_c ? c_op_index_i : h_op_index_i;
    assign op_wdata_o  = gnt_c ? c_op_wdata_i : h_op_wdata_i;
    assign op_region_o = gnt_c ? REG_CODE     : REG_HIST;

    assign h_op_ack_o = op_ack_i && !gnt_c;
    assign c_op_ack_o = op_ack_i && gnt_c;

endmodule

// File: design/codebook_unit.sv
`timescale 1ns/1ns

module codebook_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cb_req_i,
    input  logic                      cb_we_i,
    input  logic [hc_pkg::SYM_W-1:0]  cb_sym_i,
    input  logic [hc_pkg::LEN_W-1:0]  cb_len_i,
    input  logic [hc_pkg::CODE_W-1:0] cb_code_i,
    output logic                      cb_ack_o,
    output logic [hc_pkg::LEN_W-1:0]  cb_len_o,
    output logic [hc_pkg::CODE_W-1:0] cb_code_o,
    output logic                      op_req_o,
    output logic                      op_we_o,
    output logic [hc_pkg::SYM_W-1:0]  op_index_o,
    output logic [hc_pkg::WORD_W-1:0] op_wdata_o,
    input  logic                      op_ack_i,
    input  logic [hc_pkg::WORD_W-1:0] op_rdata_i
);
    import hc_pkg::*;

    typedef enum logic [1:0] {
        C_IDLE,
        C_OP_REQ,
        C_OP_REL,
        C_ACK
    } state_t;

    state_t            state, next;
    logic              we_q;
    logic [SYM_W-1:0]  sym_q;
    logic [LEN_W-1:0]  len_q;
    logic [CODE_W-1:0] code_q;
    logic [LEN_W-1:0]  len_res;
    logic [CODE_W-1:0] code_res;
    mem_word_u         rd_word;
    mem_word_u         wr_word;

    assign rd_word = op_rdata_i;

    // pack the entry, length in the top bits
    always_comb begin
        wr_word.cb.len  = len_q;
        wr_word.cb.code = code_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= C_IDLE;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        case (state)
            C_IDLE: begin
                if (cb_req_i) begin
                    next = C_OP_REQ;
                end
            end
            C_OP_REQ: begin
                if (op_ack_i) begin
                    next = C_OP_REL;
                end
            end
            C_OP_REL: begin
                if (!op_ack_i) begin
                    next = C_ACK;  // port handshake fully closed
                end
            end
            C_ACK: begin
                if (!cb_req_i) begin
                    next = C_IDLE;
                end
            end
            default: next = C_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == C_IDLE && cb_req_i) begin
            we_q   <= cb_we_i;
            sym_q  <= cb_sym_i;
            len_q  <= cb_len_i;
            code_q <= cb_code_i;
        end
        if (state == C_OP_REQ && op_ack_i) begin
            // a write echoes what was stored
            len_res  <= we_q ? len_q  : rd_word.cb.len;
            code_res <= we_q ? code_q : rd_word.cb.code;
        end
    end

    assign op_req_o   = (state == C_OP_REQ);
    assign op_we_o    = we_q;
    assign op_index_o = sym_q;
    assign op_wdata_o = wr_word;
    assign cb_ack_o   = (state == C_ACK);
    assign cb_len_o   = len_res;   // held until the next op
    assign cb_code_o  = code_res;

endmodule

// File: design/hc_mem_top.sv
`timescale 1ns/1ns

module hc_mem_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sym_req_i,
    input  logic                      sym_query_i,
    input  logic [hc_pkg::SYM_W-1:0]  sym_i,
    output logic                      sym_ack_o,
    output logic [hc_pkg::WORD_W-1:0] hist_count_o,
    input  logic                      cb_req_i,
    input  logic                      cb_we_i,
    input  logic [hc_pkg::SYM_W-1:0]  cb_sym_i,
    input  logic [hc_pkg::LEN_W-1:0]  cb_len_i,
    input  logic [hc_pkg::CODE_W-1:0] cb_code_i,
    output logic                      cb_ack_o,
    output logic [hc_pkg::LEN_W-1:0]  cb_len_o,
    output logic [hc_pkg::CODE_W-1:0] cb_code_o,
    output logic                      busy_o
);
    import hc_pkg::*;

    // client side of the arbiter
    logic                h_op_req, h_op_we, h_op_ack;
    logic [SYM_W-1:0]    h_op_index;
    logic [WORD_W-1:0]   h_op_wdata;
    logic                c_op_req, c_op_we, c_op_ack;
    logic [SYM_W-1:0]    c_op_index;
    logic [WORD_W-1:0]   c_op_wdata;
    logic [WORD_W-1:0]   op_rdata;  // shared by both clients

    // arbiter to port
    logic                op_req, op_we, op_ack;
    logic [REGION_W-1:0] op_region;
    logic [SYM_W-1:0]    op_index;
    logic [WORD_W-1:0]   op_wdata;

    // port to memory
    logic                mem_req, mem_we, mem_ack;
    logic [ADDR_W-1:0]   mem_addr;
    logic [WORD_W-1:0]   mem_wdata, mem_rdata;

    hist_update u_hist (
        .clk, .rst, .sym_req_i, .sym_query_i, .sym_i, .sym_ack_o, .hist_count_o,
        .op_req_o(h_op_req), .op_we_o(h_op_we), .op_index_o(h_op_index),
        .op_wdata_o(h_op_wdata), .op_ack_i(h_op_ack), .op_rdata_i(op_rdata)
    );

    codebook_unit u_code (
        .clk, .rst, .cb_req_i, .cb_we_i, .cb_sym_i, .cb_len_i, .cb_code_i,
        .cb_ack_o, .cb_len_o, .cb_code_o,
        .op_req_o(c_op_req), .op_we_o(c_op_we), .op_index_o(c_op_index),
        .op_wdata_o(c_op_wdata), .op_ack_i(c_op_ack), .op_rdata_i(op_rdata)
    );

    client_arbiter u_arb (
        .clk, .rst,
        .h_op_req_i(h_op_req), .h_op_we_i(h_op_we), .h_op_index_i(h_op_index),
        .h_op_wdata_i(h_op_wdata), .h_op_ack_o(h_op_ack),
        .c_op_req_i(c_op_req), .c_op_we_i(c_op_we), .c_op_index_i(c_op_index),
        .c_op_wdata_i(c_op_wdata), .c_op_ack_o(c_op_ack),
        .op_req_o(op_req), .op_we_o(op_we), .op_region_o(op_region),
        .op_index_o(op_index), .op_wdata_o(op_wdata), .op_ack_i(op_ack)
    );

    sram_port u_port (
        .clk, .rst,
        .op_req_i(op_req), .op_we_i(op_we), .op_region_i(op_region),
        .op_index_i(op_index), .op_wdata_i(op_wdata), .op_ack_o(op_ack),
        .op_rdata_o(op_rdata), .busy_o,
        .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
        .mem_wdata_o(mem_wdata), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata)
    );

    word_ram u_ram (
        .clk, .rst,
        .mem_req_i(mem_req), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
        .mem_wdata_i(mem_wdata), .mem_ack_o(mem_ack), .mem_rdata_o(mem_rdata)
    );

endmodule

// File: design/hc_pkg.sv
package hc_pkg;

    // symbol and memory geometry
    localparam int SYM_W     = 8;
    localparam int WORD_W    = 32;
    localparam int ADDR_W    = 10;
    localparam int MEM_DEPTH = 1 << ADDR_W;  // 1024 words

    // region codes, one per client
    localparam int REGION_W = 2;
    localparam logic [REGION_W-1:0] REG_HIST = 2'd0;
    localparam logic [REGION_W-1:0] REG_CODE = 2'd1;

    // word bases of each region
    localparam logic [ADDR_W-1:0] HIST_BASE = 10'h000;
    localparam logic [ADDR_W-1:0] CODE_BASE = 10'h300;

    // codebook entry fields, len sits above code
    localparam int LEN_W  = 5;
    localparam int CODE_W = 27;

    // histogram counts stick here instead of wrapping
    localparam logic [WORD_W-1:0] COUNT_MAX = '1;

    typedef struct packed {
        logic [WORD_W-1:0] count;
    } hist_view_t;

    typedef struct packed {
        logic [LEN_W-1:0]  len;   // code length in bits
        logic [CODE_W-1:0] code;  // right aligned code bits
    } cb_view_t;

    // one memory word, read as a count or as a codebook entry
    typedef union packed {
        hist_view_t hist;
        cb_view_t   cb;
    } mem_word_u;

endpackage

// File: design/hist_update.sv
`timescale 1ns/1ns

module hist_update (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sym_req_i,
    input  logic                      sym_query_i,
    input  logic [hc_pkg::SYM_W-1:0]  sym_i,
    output logic                      sym_ack_o,
    output logic [hc_pkg::WORD_W-1:0] hist_count_o,
    output logic                      op_req_o,
    output logic                      op_we_o,
    output logic [hc_pkg::SYM_W-1:0]  op_index_o,
    output logic [hc_pkg::WORD_W-1:0] op_wdata_o,
    input  logic                      op_ack_i,
    input  logic [hc_pkg::WORD_W-1:0] op_rdata_i
);
    import hc_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_REQ,
        S_RD_REL,
        S_WR_REQ,
        S_WR_REL,
        S_ACK
    } state_t;

    state_t            state, next;
    logic [SYM_W-1:0]  sym_q;
    logic              query_q;
    logic [WORD_W-1:0] count_q;
    mem_word_u         rd_word;
    mem_word_u         wr_word;

    assign rd_word = op_rdata_i;

    always_comb begin
        wr_word.hist.count = count_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= next;
        end
    end

    always_comb begin
        next = state;
        case (state)
            S_IDLE:   if (sym_req_i) next = S_RD_REQ;
            S_RD_REQ: if (op_ack_i) next = S_RD_REL;
            S_RD_REL: if (!op_ack_i) next = query_q ? S_ACK : S_WR_REQ;
            S_WR_REQ: if (op_ack_i) next = S_WR_REL;
            S_WR_REL: if (!op_ack_i) next = S_ACK;
            S_ACK:    if (!sym_req_i) next = S_IDLE;
            default:  next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && sym_req_i) begin
            sym_q   <= sym_i;
            query_q <= sym_query_i;
        end
        if (state == S_RD_REQ && op_ack_i) begin
            // saturate instead of wrapping to zero
            if (query_q || rd_word.hist.count == COUNT_MAX) begin
                count_q <= rd_word.hist.count;
            end else begin
                count_q <= rd_word.hist.count + 1'b1;
            end
        end
    end

    assign op_req_o     = (state == S_RD_REQ) || (state == S_WR_REQ);
    assign op_we_o      = (state == S_WR_REQ);
    assign op_index_o   = sym_q;
    assign op_wdata_o   = wr_word;
    assign sym_ack_o    = (state == S_ACK);
    assign hist_count_o = count_q;  // count after the op

endmodule

// File: design/sram_port.sv
`timescale 1ns/1ns

module sram_port (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        op_req_i,
    input  logic                        op_we_i,
    input  logic [hc_pkg::REGION_W-1:0] op_region_i,
    input  logic [hc_pkg::SYM_W-1:0]    op_index_i,
    input  logic [hc_pkg::WORD_W-1:0]   op_wdata_i,
    output logic                        op_ack_o,
    output logic [hc_pkg::WORD_W-1:0]   op_rdata_o,
    output logic                        busy_o,
    output logic                        mem_req_o,
    output logic                        mem_we_o,
    output logic [hc_pkg::ADDR_W-1:0]   mem_addr_o,
    output logic [hc_pkg::WORD_W-1:0]   mem_wdata_o,
    input  logic                        mem_ack_i,
    input  logic [hc_pkg::WORD_W-1:0]   mem_rdata_i
);
    import hc_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_PREP,
        W_COMMIT,
        W_DONE
    } wr_state_t;

    typedef enum logic [2:0] {
        R_IDLE,
        R_LATCH_ADDR,
        R_DO_READ,
        R_WAIT_DATA,
        R_DONE
    } rd_state_t;

    wr_state_t           w_state, w_next;
    rd_state_t           r_state, r_next;
    logic                idle;
    logic [REGION_W-1:0] region_q;
    logic [SYM_W-1:0]    index_q;
    logic [WORD_W-1:0]   wdata_q;
    logic [ADDR_W-1:0]   base;
    logic [ADDR_W-1:0]   addr_q;

    assign idle = (w_state == W_IDLE) && (r_state == R_IDLE);

    always_comb begin
        case (region_q)
            REG_HIST: base = HIST_BASE;
            REG_CODE: base = CODE_BASE;
            default:  base = HIST_BASE;  // unused codes fall back to histogram
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            w_state <= W_IDLE;
            r_state <= R_IDLE;
        end else begin
            w_state <= w_next;
            r_state <= r_next;
        end
    end

    // write sequence
    always_comb begin
        w_next = w_state;
        case (w_state)
            W_IDLE: begin
                if (idle && op_req_i && op_we_i) begin
                    w_next = W_PREP;
                end
            end
            W_PREP:   w_next = W_COMMIT;  // address settles
            W_COMMIT: begin
                if (mem_ack_i) begin
                    w_next = W_DONE;
                end
            end
            W_DONE: begin
                // memory must let go too before the next op
                if (!op_req_i && !mem_ack_i) begin
                    w_next = W_IDLE;
                end
            end
            default: w_next = W_IDLE;
        endcase
    end

    // read sequence
    always_comb begin
        r_next = r_state;
        case (r_state)
            R_IDLE: begin
                if (idle && op_req_i && !op_we_i) begin
                    r_next = R_LATCH_ADDR;
                end
            end
            R_LATCH_ADDR: r_next = R_DO_READ;
            R_DO_READ: begin
                if (mem_ack_i) begin
                    r_next = R_WAIT_DATA;
                end
            end
            R_WAIT_DATA: begin
                if (!mem_ack_i) begin
                    r_next = R_DONE;
                end
            end
            R_DONE: begin
                if (!op_req_i) begin
                    r_next = R_IDLE;
                end
            end
            default: r_next = R_IDLE;
        endcase
    end

    // request latch, address forming and read capture
    always_ff @(posedge clk) begin
        if (idle && op_req_i) begin
            region_q <= op_region_i;
            index_q  <= op_index_i;
            wdata_q  <= op_wdata_i;
        end
        if (w_state == W_PREP || r_state == R_LATCH_ADDR) begin
            addr_q <= base + {{(ADDR_W - SYM_W){1'b0}}, index_q};
        end
        if (r_state == R_WAIT_DATA && !mem_ack_i) begin
            op_rdata_o <= mem_rdata_i;  // ram holds its data after ack
        end
    end

    assign mem_req_o   = (w_state == W_COMMIT) || (r_state == R_DO_READ);
    assign mem_we_o    = (w_state == W_COMMIT);
    assign mem_addr_o  = addr_q;
    assign mem_wdata_o = wdata_q;
    assign op_ack_o    = (w_state == W_DONE) || (r_state == R_DONE);
    assign busy_o      = !idle;

endmodule

// File: design/word_ram.sv
`timescale 1ns/1ns

module word_ram (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mem_req_i,
    input  logic                      mem_we_i,
    input  logic [hc_pkg::ADDR_W-1:0] mem_addr_i,
    input  logic [hc_pkg::WORD_W-1:0] mem_wdata_i,
    output logic                      mem_ack_o,
    output logic [hc_pkg::WORD_W-1:0] mem_rdata_o
);
    import hc_pkg::*;

    logic [WORD_W-1:0]    mem [MEM_DEPTH];
    logic [MEM_DEPTH-1:0] written;  // one flag per word
    logic                 start;

    assign start = mem_req_i && !mem_ack_o;  // fresh request

    // slave side of the handshake, plus the written flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_ack_o <= 1'b0;
            written   <= '0;
        end else if (start) begin
            mem_ack_o <= 1'b1;
            if (mem_we_i) begin
                written[mem_addr_i] <= 1'b1;
            end
        end else if (!mem_req_i && mem_ack_o) begin
            mem_ack_o <= 1'b0;  // req gone, release
        end
    end

    // untouched words read as zero, so the histogram starts clean
    always_ff @(posedge clk) begin
        if (start) begin
            if (mem_we_i) begin
                mem[mem_addr_i] <= mem_wdata_i;
            end else begin
                mem_rdata_o <= written[mem_addr_i] ? mem[mem_addr_i] : '0;
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it
# the exit status is the simulator's, nonzero on any failure
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_hc_mem -f build.f -o sim_hc_mem
./obj_dir/sim_hc_mem
